// ==== source/sensorBus_settings.svh ====
`ifndef SENSORBUS_SETTINGS_SVH
`define SENSORBUS_SETTINGS_SVH

// Bus widths
`define SB_DATA_W       8
`define SB_DEV_W        7
`define SB_AXI_AW       8
`define SB_AXI_DW       32

// Register offsets
`define SB_REG_CTRL     8'h00
`define SB_REG_DEV      8'h04
`define SB_REG_ADDR     8'h08
`define SB_REG_WDATA    8'h0C
`define SB_REG_STATUS   8'h10
`define SB_REG_RDATA    8'h14

// FSM_Clk cycles per quarter bit, 1 to 255
`define SB_QUARTER_CLKS 1

`endif

// ==== source/sensorBusPkg.sv ====
`default_nettype none

package sensorBusPkg;

    typedef enum logic [1:0] {
        cmdNone  = 2'd0,
        cmdWrite = 2'd1,
        cmdRead  = 2'd2
    } busCmd_t;

    // Steps the bit engine can carry out
    typedef enum logic [2:0] {
        stepStart,
        stepRestart,
        stepStop,
        stepSendByte,
        stepRecvNack
    } busStep_t;

    typedef enum logic [3:0] {
        sIdle,
        sStart,
        sDevW,
        sReg,
        sData,
        sRestart,
        sDevR,
        sRecv,
        sStop,
        sWait
    } seqState_t;

endpackage

`default_nettype wire

// ==== source/sensorRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sensorBus_settings.svh"

module sensorRegs
    import sensorBusPkg::*;
(
    input  wire                   FSM_Clk,
    input  wire                   rstN,
    input  wire [`SB_AXI_AW-1:0]  awAddr,
    input  wire                   awValid,
    output logic                  awReady,
    input  wire [`SB_AXI_DW-1:0]  wData,
    input  wire [3:0]             wStrb,
    input  wire                   wValid,
    output logic                  wReady,
    output logic [1:0]            bResp,
    output logic                  bValid,
    input  wire                   bReady,
    input  wire [`SB_AXI_AW-1:0]  arAddr,
    input  wire                   arValid,
    output logic                  arReady,
    output logic [`SB_AXI_DW-1:0] rData,
    output logic [1:0]            rResp,
    output logic                  rValid,
    input  wire                   rReady,
    output logic                  cmdStart,
    output busCmd_t               cmdOp,
    output logic [`SB_DEV_W-1:0]  devAddr,
    output logic [`SB_DATA_W-1:0] regAddr,
    output logic [`SB_DATA_W-1:0] wrData,
    input  wire                   busy,
    input  wire                   ackError,
    input  wire [`SB_DATA_W-1:0]  rdByte,
    input  wire                   rdValid
);

    logic                  wrFire;
    logic                  wrOffer;
    logic [`SB_DATA_W-1:0] rdData;
    logic [`SB_AXI_DW-1:0] readMux;

    assign wrOffer = awValid && wValid && !bValid && !awReady;
    assign wrFire  = awReady && awValid && wValid;
    assign bResp   = 2'b00;
    assign rResp   = 2'b00;

    always_ff @(posedge FSM_Clk) begin
        if (!rstN) begin
            awReady  <= 1'b0;
            wReady   <= 1'b0;
            bValid   <= 1'b0;
            cmdStart <= 1'b0;
            cmdOp    <= cmdNone;
            devAddr  <= '0;
            regAddr  <= '0;
            wrData   <= '0;
        end else begin
            cmdStart <= 1'b0;
            awReady  <= wrOffer;
            wReady   <= wrOffer;
            if (wrFire) begin
                bValid <= 1'b1;
                if (wStrb[0]) begin
                    case (awAddr)
                        `SB_REG_CTRL: begin
                            // Only a real command starts a transaction
                            if (wData[1:0] == cmdWrite || wData[1:0] == cmdRead) begin
                                cmdStart <= 1'b1;
                                cmdOp    <= busCmd_t'(wData[1:0]);
                            end
                        end
                        `SB_REG_DEV:   devAddr <= wData[`SB_DEV_W-1:0];
                        `SB_REG_ADDR:  regAddr <= wData[`SB_DATA_W-1:0];
                        `SB_REG_WDATA: wrData  <= wData[`SB_DATA_W-1:0];
                        default: ;
                    endcase
                end
            end else if (bValid && bReady) begin
                bValid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (arAddr)
            `SB_REG_CTRL:   readMux = `SB_AXI_DW'(cmdOp);
            `SB_REG_DEV:    readMux = `SB_AXI_DW'(devAddr);
            `SB_REG_ADDR:   readMux = `SB_AXI_DW'(regAddr);
            `SB_REG_WDATA:  readMux = `SB_AXI_DW'(wrData);
            `SB_REG_STATUS: readMux = `SB_AXI_DW'({ackError, busy});
            `SB_REG_RDATA:  readMux = `SB_AXI_DW'(rdData);
            default:        readMux = '0;
        endcase
    end

    always_ff @(posedge FSM_Clk) begin
        if (!rstN) begin
            arReady <= 1'b0;
            rValid  <= 1'b0;
        end else if (arReady && arValid) begin
            arReady <= 1'b0;
            rValid  <= 1'b1;
        end else if (rValid) begin
            if (rReady) begin
                rValid <= 1'b0;
            end
        end else begin
            arReady <= 1'b1;
        end
    end

    always_ff @(posedge FSM_Clk) begin
        if (arReady && arValid) begin
            rData <= readMux;
        end
        if (rdValid) begin
            rdData <= rdByte;
        end
    end

endmodule

`default_nettype wire

// ==== source/i2cSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sensorBus_settings.svh"

module i2cSequencer
    import sensorBusPkg::*;
(
    input  wire                   FSM_Clk,
    input  wire                   rstN,
    input  wire                   cmdStart,
    input  wire busCmd_t          cmdOp,
    input  wire [`SB_DEV_W-1:0]   devAddr,
    input  wire [`SB_DATA_W-1:0]  regAddr,
    input  wire [`SB_DATA_W-1:0]  wrData,
    input  wire                   stepDone,
    input  wire [`SB_DATA_W-1:0]  rxByte,
    input  wire                   ackMissing,
    output logic                  busy,
    output logic                  ackError,
    output logic [`SB_DATA_W-1:0] rdByte,
    output logic                  rdValid,
    output logic                  stepValid,
    output busStep_t              step,
    output logic [`SB_DATA_W-1:0] txByte
);

    seqState_t state;
    seqState_t nextState;
    busCmd_t   op;

    // Step request and successor for each state
    always_comb begin
        stepValid = 1'b1;
        step      = stepSendByte;
        txByte    = '0;
        nextState = sIdle;
        case (state)
            sStart: begin
                step      = stepStart;
                nextState = sDevW;
            end
            sDevW: begin
                txByte    = {devAddr, 1'b0};
                nextState = sReg;
            end
            sReg: begin
                txByte    = regAddr;
                nextState = (op == cmdWrite) ? sData : sRestart;
            end
            sData: begin
                txByte    = wrData;
                nextState = sStop;
            end
            sRestart: begin
                step      = stepRestart;
                nextState = sDevR;
            end
            sDevR: begin
                txByte    = {devAddr, 1'b1};
                nextState = sRecv;
            end
            sRecv: begin
                step      = stepRecvNack;
                nextState = sStop;
            end
            sStop: begin
                step      = stepStop;
                nextState = sWait;
            end
            default: stepValid = 1'b0;
        endcase
    end

    always_ff @(posedge FSM_Clk) begin
        if (!rstN) begin
            state    <= sIdle;
            op       <= cmdNone;
            busy     <= 1'b0;
            ackError <= 1'b0;
            rdValid  <= 1'b0;
        end else begin
            rdValid <= 1'b0;
            case (state)
                sIdle: begin
                    if (cmdStart && cmdOp != cmdNone) begin
                        op       <= cmdOp;
                        busy     <= 1'b1;
                        ackError <= 1'b0;
                        state    <= sStart;
                    end
                end
                sWait: begin
                    busy    <= 1'b0;
                    rdValid <= (op == cmdRead);
                    state   <= sIdle;
                end
                default: begin
                    if (stepDone) begin
                        // Missing ACK is recorded, the transaction still runs to its stop
                        if (step == stepSendByte) begin
                            ackError <= ackError | ackMissing;
                        end
                        state <= nextState;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge FSM_Clk) begin
        if (state == sRecv && stepDone) begin
            rdByte <= rxByte;
        end
    end

endmodule

`default_nettype wire

// ==== source/i2cBitEngine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sensorBus_settings.svh"

module i2cBitEngine
    import sensorBusPkg::*;
(
    input  wire                   FSM_Clk,
    input  wire                   rstN,
    input  wire                   stepValid,
    input  wire busStep_t         step,
    input  wire [`SB_DATA_W-1:0]  txByte,
    input  wire                   sdaIn,
    output logic                  stepDone,
    output logic [`SB_DATA_W-1:0] rxByte,
    output logic                  ackMissing,
    output logic                  scl,
    output logic                  sdaLow
);

    localparam logic [7:0] quarterLast = 8'(`SB_QUARTER_CLKS - 1);

    busStep_t              curStep;
    logic                  active;
    logic                  accept;
    logic                  tick;
    logic                  lastBit;
    logic                  stepEnd;
    logic                  sclHigh;
    logic                  sclLevel;
    logic                  sdaLowLevel;
    logic [7:0]            qCnt;
    logic [1:0]            phase;
    logic [3:0]            bitCnt;
    logic [`SB_DATA_W-1:0] shiftReg;

    // No new step in the cycle that reports the previous one done
    assign accept  = !active && stepValid && !stepDone;
    assign tick    = (qCnt == quarterLast);
    assign lastBit = (bitCnt == 4'(`SB_DATA_W));
    assign stepEnd = tick && (phase == 2'd3) &&
                     (lastBit || (curStep != stepSendByte && curStep != stepRecvNack));
    assign sclHigh = (phase == 2'd1) || (phase == 2'd2);
    assign rxByte  = shiftReg;

    // Bus levels for the current quarter
    always_comb begin
        case (curStep)
            stepStart: begin
                sclLevel    = (phase != 2'd3);
                sdaLowLevel = (phase != 2'd0);
            end
            stepRestart: begin
                sclLevel    = sclHigh;
                sdaLowLevel = phase[1];
            end
            stepStop: begin
                sclLevel    = (phase != 2'd0);
                sdaLowLevel = (phase != 2'd3);
            end
            stepSendByte: begin
                sclLevel    = sclHigh;
                sdaLowLevel = !lastBit && !shiftReg[`SB_DATA_W-1];
            end
            default: begin
                // Receive bits and the closing NACK leave SDA released
                sclLevel    = sclHigh;
                sdaLowLevel = 1'b0;
            end
        endcase
    end

    always_ff @(posedge FSM_Clk) begin
        if (!rstN) begin
            curStep    <= stepStart;
            active     <= 1'b0;
            stepDone   <= 1'b0;
            ackMissing <= 1'b0;
            qCnt       <= '0;
            phase      <= '0;
            bitCnt     <= '0;
            scl        <= 1'b1;
            sdaLow     <= 1'b0;
        end else begin
            stepDone <= 1'b0;
            if (accept) begin
                curStep    <= step;
                active     <= 1'b1;
                ackMissing <= 1'b0;
                qCnt       <= '0;
                phase      <= '0;
                bitCnt     <= '0;
            end else if (active) begin
                scl    <= sclLevel;
                sdaLow <= sdaLowLevel;
                if (tick && phase == 2'd2 && lastBit) begin
                    ackMissing <= sdaIn;
                end
                if (tick) begin
                    qCnt  <= '0;
                    phase <= phase + 2'd1;
                    if (stepEnd) begin
                        active   <= 1'b0;
                        stepDone <= 1'b1;
                    end else if (phase == 2'd3) begin
                        bitCnt <= bitCnt + 4'd1;
                    end
                end else begin
                    qCnt <= qCnt + 8'd1;
                end
            end
        end
    end

    // MSB first in both directions
    always_ff @(posedge FSM_Clk) begin
        if (accept) begin
            shiftReg <= txByte;
        end else if (active && tick && !lastBit) begin
            if (curStep == stepSendByte && phase == 2'd3) begin
                shiftReg <= {shiftReg[`SB_DATA_W-2:0], 1'b0};
            end else if (curStep == stepRecvNack && phase == 2'd2) begin
                shiftReg <= {shiftReg[`SB_DATA_W-2:0], sdaIn};
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/sensorBusTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sensorBus_settings.svh"

module sensorBusTop
    import sensorBusPkg::*;
(
    input  wire                   FSM_Clk,
    input  wire                   rstN,
    input  wire [`SB_AXI_AW-1:0]  awAddr,
    input  wire                   awValid,
    output logic                  awReady,
    input  wire [`SB_AXI_DW-1:0]  wData,
    input  wire [3:0]             wStrb,
    input  wire                   wValid,
    output logic                  wReady,
    output logic [1:0]            bResp,
    output logic                  bValid,
    input  wire                   bReady,
    input  wire [`SB_AXI_AW-1:0]  arAddr,
    input  wire                   arValid,
    output logic                  arReady,
    output logic [`SB_AXI_DW-1:0] rData,
    output logic [1:0]            rResp,
    output logic                  rValid,
    input  wire                   rReady,
    output logic                  scl,
    output logic                  sdaLow,
    input  wire                   sdaIn
);

    // Host side
    logic                  cmdStart;
    busCmd_t               cmdOp;
    logic [`SB_DEV_W-1:0]  devAddr;
    logic [`SB_DATA_W-1:0] regAddr;
    logic [`SB_DATA_W-1:0] wrData;
    logic                  busy;
    logic                  ackError;
    logic [`SB_DATA_W-1:0] rdByte;
    logic                  rdValid;

    // Step handover
    logic                  stepValid;
    busStep_t              step;
    logic [`SB_DATA_W-1:0] txByte;
    logic                  stepDone;
    logic [`SB_DATA_W-1:0] rxByte;
    logic                  ackMissing;

    sensorRegs uRegs (.*);

    i2cSequencer uSeq (.*);

    i2cBitEngine uEngine (.*);

endmodule

`default_nettype wire

// ==== tb/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter real periodNs = 8.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(periodNs / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// ==== tb/sensorSlaveModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module sensorSlaveModel #(
    parameter logic [6:0] devAddress = 7'h48
) (
    input  wire  scl,
    input  wire  sda,
    output logic pullLow
);

    logic [7:0] mem [0:255];
    logic [7:0] shiftIn;
    logic [7:0] outByte;
    logic [7:0] regPtr;
    integer     writeCount;
    integer     bitCnt;
    integer     byteCnt;
    logic       started;
    logic       skipFall;
    logic       addressed;
    logic       readMode;
    logic       sending;
    logic       masterNack;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'h5A;
        end
        pullLow    = 1'b0;
        started    = 1'b0;
        sending    = 1'b0;
        addressed  = 1'b0;
        readMode   = 1'b0;
        regPtr     = 8'h00;
        writeCount = 0;
    end

    // Start or repeated start
    always @(negedge sda) begin
        if (scl) begin
            started  = 1'b1;
            skipFall = 1'b1;
            bitCnt   = 0;
            byteCnt  = 0;
            sending  = 1'b0;
            pullLow  = 1'b0;
        end
    end

    // Stop
    always @(posedge sda) begin
        if (scl) begin
            started = 1'b0;
            sending = 1'b0;
            pullLow = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (started && !sending && bitCnt < 8) begin
            shiftIn = {shiftIn[6:0], sda};
        end
        if (started && sending && bitCnt == 8) begin
            masterNack = sda;
        end
    end

    always @(negedge scl) begin
        if (!started) begin
            pullLow = 1'b0;
        end else if (skipFall) begin
            skipFall = 1'b0;
        end else if (bitCnt < 7) begin
            bitCnt = bitCnt + 1;
            if (sending) begin
                pullLow = !outByte[7 - bitCnt];
            end
        end else if (bitCnt == 7) begin
            bitCnt = 8;
            if (sending) begin
                pullLow = 1'b0;
            end else begin
                if (byteCnt == 0) begin
                    addressed = (shiftIn[7:1] == devAddress);
                    readMode  = shiftIn[0];
                end else if (addressed && !readMode) begin
                    if (byteCnt == 1) begin
                        regPtr = shiftIn;
                    end else begin
                        mem[regPtr] = shiftIn;
                        writeCount  = writeCount + 1;
                        regPtr      = regPtr + 8'd1;
                    end
                end
                pullLow = addressed;
            end
        end else begin
            // End of the ACK slot
            bitCnt  = 0;
            byteCnt = byteCnt + 1;
            pullLow = 1'b0;
            if (addressed && readMode && !(sending && masterNack)) begin
                sending = 1'b1;
                outByte = mem[regPtr];
                pullLow = !outByte[7];
            end else begin
                sending = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/sensorBusTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sensorBus_settings.svh"

module sensorBusTb;

    logic        FSM_Clk;
    logic        rstN;
    logic [7:0]  awAddr;
    logic        awValid;
    logic        awReady;
    logic [31:0] wData;
    logic [3:0]  wStrb;
    logic        wValid;
    logic        wReady;
    logic [1:0]  bResp;
    logic        bValid;
    logic        bReady;
    logic [7:0]  arAddr;
    logic        arValid;
    logic        arReady;
    logic [31:0] rData;
    logic [1:0]  rResp;
    logic        rValid;
    logic        rReady;
    logic        scl;
    logic        sdaLow;
    logic        pullLow;
    wire         sdaLine;

    logic [7:0]  testData [0:255];
    integer      checkFails;
    integer      passCount;
    integer      failCount;
    logic        testOk;

    // Open-drain line with pull-up
    assign sdaLine = (sdaLow || pullLow) ? 1'b0 : 1'b1;

    tbClock clockGen (.clk(FSM_Clk));

    sensorSlaveModel #(.devAddress(7'h48)) slave (.scl(scl), .sda(sdaLine), .pullLow(pullLow));

    sensorBusTop dut (
        .FSM_Clk(FSM_Clk), .rstN(rstN),
        .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
        .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
        .bResp(bResp), .bValid(bValid), .bReady(bReady),
        .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
        .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
        .scl(scl), .sdaLow(sdaLow), .sdaIn(sdaLine)
    );

    task automatic checkValue(input [31:0] got, input [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("FAILED %0t: %s is %0h, expected %0h", $time, what, got, exp);
            checkFails = checkFails + 1;
            testOk = 1'b0;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timed out while waiting for %s at %0t", what, $time);
        checkFails = checkFails + 1;
        testOk = 1'b0;
    endtask

    task automatic axiWrite(input [7:0] addr, input [31:0] data);
        int n;
        int stall;
        awAddr  = addr;
        wData   = data;
        wStrb   = 4'hF;
        awValid = 1'b1;
        wValid  = 1'b1;
        for (n = 0; n < 50; n++) begin
            @(negedge FSM_Clk);
            if (awReady) break;
        end
        if (!awReady) begin
            reportTimeout("awReady");
            awValid = 1'b0;
            wValid  = 1'b0;
            return;
        end
        checkValue(32'(wReady), 32'h1, "wReady");
        @(negedge FSM_Clk);
        awValid = 1'b0;
        wValid  = 1'b0;
        for (n = 0; n < 50 && !bValid; n++) begin
            @(negedge FSM_Clk);
        end
        if (!bValid) begin
            reportTimeout("bValid");
            return;
        end
        checkValue(32'(bResp), 32'h0, "bResp");
        stall = $urandom % 4;
        repeat (stall) begin
            @(negedge FSM_Clk);
            assert (bValid && bResp == 2'b00) else begin
                $display("FAILED %0t: write response changed during stall", $time);
                checkFails = checkFails + 1;
                testOk = 1'b0;
            end
        end
        bReady = 1'b1;
        @(negedge FSM_Clk);
        bReady = 1'b0;
    endtask

    task automatic axiRead(input [7:0] addr, output [31:0] data);
        int n;
        int stall;
        data    = '0;
        arAddr  = addr;
        arValid = 1'b1;
        for (n = 0; n < 50; n++) begin
            @(negedge FSM_Clk);
            if (rValid) break;
        end
        arValid = 1'b0;
        if (!rValid) begin
            reportTimeout("rValid");
            return;
        end
        data  = rData;
        checkValue(32'(rResp), 32'h0, "rResp");
        stall = $urandom % 4;
        repeat (stall) begin
            @(negedge FSM_Clk);
            // No new read address is taken while data is pending
            assert (rValid && rData === data && !arReady) else begin
                $display("FAILED %0t: read response changed during stall", $time);
                checkFails = checkFails + 1;
                testOk = 1'b0;
            end
        end
        rReady = 1'b1;
        @(negedge FSM_Clk);
        rReady = 1'b0;
    endtask

    task automatic configure(input [7:0] dev, input [7:0] regA, input [7:0] wd);
        axiWrite(`SB_REG_DEV, 32'(dev));
        axiWrite(`SB_REG_ADDR, 32'(regA));
        axiWrite(`SB_REG_WDATA, 32'(wd));
    endtask

    task automatic waitIdle(output [31:0] status);
        int n;
        status = 32'h1;
        for (n = 0; n < 200 && status[0]; n++) begin
            axiRead(`SB_REG_STATUS, status);
        end
        if (status[0]) begin
            reportTimeout("busy to fall");
        end
    endtask

    task automatic runTest(input [7:0] op, input [7:0] dev, input [7:0] regA,
                           input [7:0] wd, input [7:0] expAck, input [7:0] expRd);
        logic [31:0] value;
        integer      countBefore;
        case (op)
            8'h0: begin
                configure(dev, regA, wd);
                axiRead(`SB_REG_DEV, value);
                checkValue(value, 32'(dev), "DEV");
                axiRead(`SB_REG_ADDR, value);
                checkValue(value, 32'(regA), "ADDR");
                axiRead(`SB_REG_WDATA, value);
                checkValue(value, 32'(wd), "WDATA");
                axiRead(8'h3C, value);
                checkValue(value, 32'h0, "unmapped offset");
            end
            8'h1, 8'h2: begin
                configure(dev, regA, wd);
                axiWrite(`SB_REG_CTRL, 32'(op));
                waitIdle(value);
                checkValue(32'(value[1]), 32'(expAck), "ackError");
                if (op == 8'h1 && expAck == 8'h0) begin
                    checkValue(32'(slave.mem[regA]), 32'(wd), "sensor register");
                end
                if (op == 8'h2) begin
                    axiRead(`SB_REG_RDATA, value);
                    checkValue(value, 32'(expRd), "RDATA");
                end
            end
            default: begin
                configure(dev, regA, wd);
                countBefore = slave.writeCount;
                axiWrite(`SB_REG_CTRL, 32'h1);
                axiRead(`SB_REG_STATUS, value);
                checkValue(32'(value[0]), 32'h1, "busy after command");
                axiWrite(`SB_REG_CTRL, 32'h1);
                waitIdle(value);
                // A second transaction would raise busy again
                axiRead(`SB_REG_STATUS, value);
                checkValue(32'(value[0]), 32'h0, "busy after completion");
                checkValue(32'(slave.writeCount - countBefore), 32'h1, "sensor write count");
                checkValue(32'(slave.mem[regA]), 32'(wd), "sensor register");
            end
        endcase
    endtask

    initial begin
        int t;
        void'($urandom(26083));
        rstN       = 1'b0;
        awAddr     = '0;
        awValid    = 1'b0;
        wData      = '0;
        wStrb      = '0;
        wValid     = 1'b0;
        bReady     = 1'b0;
        arAddr     = '0;
        arValid    = 1'b0;
        rReady     = 1'b0;
        checkFails = 0;
        passCount  = 0;
        failCount  = 0;
        $readmemh("tb/sensorBus_input.txt", testData);
        repeat (16) @(negedge FSM_Clk);
        rstN = 1'b1;
        @(negedge FSM_Clk);
        for (t = 0; t < 40 && testData[t * 6] != 8'hFF; t++) begin
            testOk = 1'b1;
            runTest(testData[t * 6], testData[t * 6 + 1], testData[t * 6 + 2],
                    testData[t * 6 + 3], testData[t * 6 + 4], testData[t * 6 + 5]);
            $display("Test %0d (op %0h): %s", t, testData[t * 6], testOk ? "ok" : "bad");
            if (testOk) begin
                passCount = passCount + 1;
            end else begin
                failCount = failCount + 1;
            end
        end
        $display("Tests passed %0d, tests failed %0d, failed checks %0d",
                 passCount, failCount, checkFails);
        if (checkFails == 0 && passCount > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/sensorBusPkg.sv
source/sensorRegs.sv
source/i2cSequencer.sv
source/i2cBitEngine.sv
source/sensorBusTop.sv
tb/tbClock.sv
tb/sensorSlaveModel.sv
tb/sensorBusTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --timing -Wno-fatal
TOP        ?= sensorBusTb
FILELIST   ?= sources.f
PASS_TEXT  := Simulation finished: PASS
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/sensorBus_input.txt ====
// op dev reg wdata expAck expRead (hex); op 0 regs, 1 write, 2 read, 3 busy
// op ff ends the list
00 48 10 a5 00 00
01 48 10 a5 00 00
02 48 10 00 00 a5
01 48 22 3c 00 00
02 48 22 00 00 3c
01 50 33 77 01 00
02 50 33 00 01 ff
03 48 44 99 00 00
ff 00 00 00 00 00
